// ==== sim.f ====
+incdir+tests
source/mbc_pkg.sv
source/cart_header_decode.sv
source/bus_decode.sv
source/bank_registers.sv
source/address_map.sv
source/cart_ram_result.sv
source/cart_mapper_top.sv
tests/tb_cart_mapper.sv

// ==== source/address_map.sv ====
// ROM and cart RAM address mapping
`timescale 1ns/1ps
`default_nettype none

module address_map #(
	parameter int RAM_BANKS_LOG2 = 4
) (
	input  wire mbc_pkg::cpu_addr_t   cur_addr,
	input  wire mbc_pkg::mbc_kind_t   kind,
	input  wire mbc_pkg::rom_bank_t   rom_bank_reg,
	input  wire mbc_pkg::ram_bank_t   ram_bank_reg,
	input  wire                       mbc1_mode,
	input  wire mbc_pkg::rom_bank_t   rom_mask,
	input  wire mbc_pkg::ram_bank_t   ram_mask,
	output mbc_pkg::rom_addr_t        rom_addr,
	output logic [RAM_BANKS_LOG2+12:0] ram_addr
);

	mbc_pkg::rom_bank_t eff_bank;    // register, or 0 for the fixed window
	logic [1:0]         bank2;       // mbc1 upper bits
	mbc_pkg::rom_bank_t rom_bank;    // before masking
	mbc_pkg::ram_bank_t ram_bank;
	mbc_pkg::ram_bank_t ram_bank_m;

	// 0000-3fff is bank 0 unless mbc1 mode 1 lifts it via bank2
	assign eff_bank = (cur_addr[15:14] == 2'b00) ? 9'd0 : rom_bank_reg;
	assign bank2    = ram_bank_reg[1:0] & {2{cur_addr[14] | mbc1_mode}};

	// ----------------------------------------------------------
	// rom side
	// ----------------------------------------------------------

	always_comb begin
		case (kind)
			mbc_pkg::kind_mbc1: rom_bank = {2'b00, bank2, eff_bank[4:0]};
			mbc_pkg::kind_mbc2: rom_bank = {2'b00, eff_bank[6:0]};   // 16 banks after masking
			mbc_pkg::kind_mbc3: rom_bank = {2'b00, eff_bank[6:0]};
			mbc_pkg::kind_mbc5: rom_bank = eff_bank;                 // full 9 bits
			default:            rom_bank = {8'd0, cur_addr[14]};     // plain 32k
		endcase
	end

	// mask gives mirroring on small roms
	assign rom_addr = {rom_bank & rom_mask, cur_addr[13:0]};

	// ----------------------------------------------------------
	// cart ram side
	// ----------------------------------------------------------

	always_comb begin
		case (kind)
			mbc_pkg::kind_mbc1: ram_bank = {2'b00, bank2};
			mbc_pkg::kind_mbc3: ram_bank = ram_bank_reg;
			mbc_pkg::kind_mbc5: ram_bank = ram_bank_reg;
			default:            ram_bank = '0;   // mbc2 and no mbc have one bank
		endcase
	end

	assign ram_bank_m = ram_bank & ram_mask;
	assign ram_addr   = {ram_bank_m[RAM_BANKS_LOG2-1:0], cur_addr[12:0]};  // extra banks fold

endmodule

`default_nettype wire

// ==== source/bank_registers.sv ====
// MBC bank registers
`timescale 1ns/1ps
`default_nettype none

module bank_registers (
	input  wire                     clk_sys,
	input  wire                     reset,
	input  wire                     do_write,
	input  wire                     is_rom_area,
	input  wire mbc_pkg::cpu_addr_t cur_addr,
	input  wire mbc_pkg::cpu_data_t cur_wdata,
	input  wire mbc_pkg::mbc_kind_t kind,
	output mbc_pkg::rom_bank_t      rom_bank_reg,
	output mbc_pkg::ram_bank_t      ram_bank_reg,
	output logic                    mbc1_mode,    // 1 lets bank2 reach 0000-3fff and ram
	output logic                    rtc_mode,     // mbc3 rtc mapped at a000
	output logic                    ram_enable
);

	logic reg_wr;   // cpu write into the register window
	logic is_mbc1;
	logic is_mbc3;
	logic is_mbc5;

	assign reg_wr  = do_write && is_rom_area;
	assign is_mbc1 = (kind == mbc_pkg::kind_mbc1);
	assign is_mbc3 = (kind == mbc_pkg::kind_mbc3);
	assign is_mbc5 = (kind == mbc_pkg::kind_mbc5);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_bank_reg <= 9'd1;
			ram_bank_reg <= '0;
			mbc1_mode    <= 1'b0;
			rtc_mode     <= 1'b0;
			ram_enable   <= 1'b0;
		end else if (reg_wr) begin
			case (cur_addr[15:13])
				// ------------------------------------------------
				// 0000-1fff ram enable
				// ------------------------------------------------
				3'b000: ram_enable <= (cur_wdata[3:0] == 4'ha);  // only 0a opens it

				// ------------------------------------------------
				// 2000-3fff rom bank
				// ------------------------------------------------
				3'b001: begin
					if (is_mbc5) begin
						if (cur_addr[12])
							rom_bank_reg[8] <= cur_wdata[0];        // 3000-3fff high bit
						else
							rom_bank_reg[7:0] <= cur_wdata;         // 2000-2fff low byte
					end else if (cur_wdata[6:0] == 7'd0) begin
						rom_bank_reg <= 9'd1;   // bank 0 aliases to 1 on mbc1-3
					end else begin
						rom_bank_reg <= {2'b00, cur_wdata[6:0]};
					end
				end

				// ------------------------------------------------
				// 4000-5fff ram bank or rtc select
				// ------------------------------------------------
				3'b010: begin
					if (is_mbc3) begin
						if (cur_wdata[3]) begin
							rtc_mode <= 1'b1;   // 08-0c pick an rtc register
						end else begin
							rtc_mode     <= 1'b0;
							ram_bank_reg <= {2'b00, cur_wdata[1:0]};
						end
					end else if (is_mbc5) begin
						ram_bank_reg <= cur_wdata[3:0];   // 16 banks
					end else begin
						ram_bank_reg <= {2'b00, cur_wdata[1:0]};   // mbc1 bank2 lives here
					end
				end

				// 6000-7fff banking mode, mbc1 only
				3'b011: begin
					if (is_mbc1)
						mbc1_mode <= cur_wdata[0];
				end

				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== source/bus_decode.sv ====
// Cartridge bus request decode
`timescale 1ns/1ps
`default_nettype none

module bus_decode (
	input  wire                     clk_sys,
	input  wire                     reset,
	input  wire                     req,
	input  wire                     we,
	input  wire mbc_pkg::cpu_addr_t addr,
	input  wire mbc_pkg::cpu_data_t wdata,
	input  wire                     ack_done,   // registered ack from the result stage
	output mbc_pkg::cpu_addr_t      cur_addr,
	output logic                    cur_we,
	output mbc_pkg::cpu_data_t      cur_wdata,
	output logic                    do_write,
	output logic                    do_read,
	output logic                    is_rom_area,
	output logic                    is_ram_area,
	output logic                    respond
);

	mbc_pkg::bus_state_t state;

	// ----------------------------------------------------------
	// sequencer
	// ----------------------------------------------------------

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= mbc_pkg::st_idle;
		end else begin
			case (state)
				mbc_pkg::st_idle: begin
					if (req)
						state <= mbc_pkg::st_issue;
				end
				mbc_pkg::st_issue:   state <= mbc_pkg::st_execute;
				mbc_pkg::st_execute: state <= mbc_pkg::st_respond;
				mbc_pkg::st_respond: state <= mbc_pkg::st_release;
				mbc_pkg::st_release: begin
					// host holds req as long as it likes
					if (!(req && ack_done))
						state <= mbc_pkg::st_idle;
				end
				default: state <= mbc_pkg::st_idle;
			endcase
		end
	end

	// request is captured once, on the way into issue
	always_ff @(posedge clk_sys) begin
		if (state == mbc_pkg::st_idle && req) begin
			cur_addr  <= addr;
			cur_we    <= we;
			cur_wdata <= wdata;
		end
	end

	// ----------------------------------------------------------
	// strobes and region flags
	// ----------------------------------------------------------

	assign do_write = (state == mbc_pkg::st_execute) && cur_we;   // single cycle
	assign do_read  = (state == mbc_pkg::st_execute) && !cur_we;
	assign respond  = (state == mbc_pkg::st_respond);

	assign is_rom_area = !cur_addr[15];                  // 0000-7fff, reads rom, writes regs
	assign is_ram_area = (cur_addr[15:13] == 3'b101);   // a000-bfff

endmodule

`default_nettype wire

// ==== source/cart_header_decode.sv ====
// Cartridge header capture
`timescale 1ns/1ps
`default_nettype none

module cart_header_decode (
	input  wire                     clk_sys,
	input  wire                     reset,
	input  wire                     dl_wr,    // one word per clock
	input  wire mbc_pkg::cpu_addr_t dl_addr,
	input  wire mbc_pkg::dl_word_t  dl_data,
	output mbc_pkg::mbc_kind_t      kind,
	output mbc_pkg::rom_bank_t      rom_mask,
	output mbc_pkg::ram_bank_t      ram_mask
);

	// raw header bytes, power up as an empty cartridge
	// fields persist until the next download
	mbc_pkg::size_code_t type_code = '0;
	mbc_pkg::size_code_t rom_size  = '0;
	mbc_pkg::size_code_t ram_size  = '0;

	mbc_pkg::mbc_kind_t kind_next;
	mbc_pkg::rom_bank_t rom_mask_next;
	mbc_pkg::ram_bank_t ram_mask_next;
	logic [9:0]         rom_span;  // 2 << code, one bit wider than a bank

	always @(posedge clk_sys) begin
		if (dl_wr && dl_addr == mbc_pkg::HDR_TYPE_ADDR)
			type_code <= dl_data[15:8];
		if (dl_wr && dl_addr == mbc_pkg::HDR_SIZE_ADDR)
			{ram_size, rom_size} <= dl_data;
	end

	always_comb begin
		case (type_code)
			8'h01, 8'h02, 8'h03:                      kind_next = mbc_pkg::kind_mbc1;
			8'h05, 8'h06:                             kind_next = mbc_pkg::kind_mbc2;
			8'h0f, 8'h10, 8'h11, 8'h12, 8'h13:        kind_next = mbc_pkg::kind_mbc3;
			8'h19, 8'h1a, 8'h1b, 8'h1c, 8'h1d, 8'h1e: kind_next = mbc_pkg::kind_mbc5;
			default:                                  kind_next = mbc_pkg::kind_none;
		endcase
	end

	// codes 0-8 give 2..512 banks, anything odd falls back to 128
	assign rom_span      = 10'd2 << rom_size[3:0];
	assign rom_mask_next = (rom_size <= 8'd8) ? rom_span[8:0] - 9'd1 : 9'd127;

	assign ram_mask_next = (ram_size <= 8'd2) ? 4'h0 :  // none, 2k or a single 8k bank
		(ram_size == 8'd3) ? 4'h3 :                     // 32k, 4 banks
		4'hf;                                           // 128k, 16 banks

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			kind     <= mbc_pkg::kind_none;
			rom_mask <= 9'd1;  // 32k direct map
			ram_mask <= '0;
		end else begin
			kind     <= kind_next;
			rom_mask <= rom_mask_next;
			ram_mask <= ram_mask_next;
		end
	end

endmodule

`default_nettype wire

// ==== source/cart_mapper_top.sv ====
// Cartridge mapper top level
`timescale 1ns/1ps
`default_nettype none

module cart_mapper_top #(
	parameter int RAM_BANKS_LOG2 = 4   // 16 banks of 8k
) (
	input  wire                      clk_sys,
	input  wire                      reset,
	// header download
	input  wire                      dl_wr,
	input  wire mbc_pkg::cpu_addr_t  dl_addr,
	input  wire mbc_pkg::dl_word_t   dl_data,
	// cpu side, four-phase req/ack
	input  wire                      req,
	input  wire                      we,
	input  wire mbc_pkg::cpu_addr_t  addr,
	input  wire mbc_pkg::cpu_data_t  wdata,
	output wire                      ack,
	output wire mbc_pkg::cpu_data_t  rdata,
	// external rom
	output wire mbc_pkg::rom_addr_t  rom_addr,
	input  wire mbc_pkg::cpu_data_t  rom_data
);

	// decode stage outputs
	wire mbc_pkg::cpu_addr_t  cur_addr;
	wire mbc_pkg::cpu_data_t  cur_wdata;
	wire                      do_write;
	wire                      do_read;
	wire                      is_rom_area;
	wire                      is_ram_area;
	wire                      respond;

	// controller state
	wire mbc_pkg::mbc_kind_t  kind;
	wire mbc_pkg::rom_bank_t  rom_mask;
	wire mbc_pkg::ram_bank_t  ram_mask;
	wire mbc_pkg::rom_bank_t  rom_bank_reg;
	wire mbc_pkg::ram_bank_t  ram_bank_reg;
	wire                      mbc1_mode;
	wire                      rtc_mode;
	wire                      ram_enable;
	wire [RAM_BANKS_LOG2+12:0] ram_addr;

	cart_header_decode header_decode_inst (
		.clk_sys(clk_sys), .reset(reset),
		.dl_wr(dl_wr), .dl_addr(dl_addr), .dl_data(dl_data),
		.kind(kind), .rom_mask(rom_mask), .ram_mask(ram_mask)
	);

	bus_decode bus_decode_inst (
		.clk_sys(clk_sys), .reset(reset),
		.req(req), .we(we), .addr(addr), .wdata(wdata),
		.ack_done(ack),
		.cur_addr(cur_addr), .cur_we(), .cur_wdata(cur_wdata),   // write flag stays inside
		.do_write(do_write), .do_read(do_read),
		.is_rom_area(is_rom_area), .is_ram_area(is_ram_area), .respond(respond)
	);

	bank_registers bank_registers_inst (
		.clk_sys(clk_sys), .reset(reset),
		.do_write(do_write), .is_rom_area(is_rom_area),
		.cur_addr(cur_addr), .cur_wdata(cur_wdata), .kind(kind),
		.rom_bank_reg(rom_bank_reg), .ram_bank_reg(ram_bank_reg),
		.mbc1_mode(mbc1_mode), .rtc_mode(rtc_mode), .ram_enable(ram_enable)
	);

	address_map #(.RAM_BANKS_LOG2(RAM_BANKS_LOG2)) address_map_inst (
		.cur_addr(cur_addr), .kind(kind),
		.rom_bank_reg(rom_bank_reg), .ram_bank_reg(ram_bank_reg), .mbc1_mode(mbc1_mode),
		.rom_mask(rom_mask), .ram_mask(ram_mask),
		.rom_addr(rom_addr), .ram_addr(ram_addr)
	);

	cart_ram_result #(.RAM_BANKS_LOG2(RAM_BANKS_LOG2)) cart_ram_result_inst (
		.clk_sys(clk_sys), .reset(reset),
		.do_write(do_write), .do_read(do_read), .respond(respond), .req(req),
		.is_rom_area(is_rom_area), .is_ram_area(is_ram_area),
		.cur_addr(cur_addr), .cur_wdata(cur_wdata), .ram_addr(ram_addr),
		.kind(kind), .ram_enable(ram_enable), .rtc_mode(rtc_mode),
		.rom_data(rom_data), .rdata(rdata), .ack(ack)
	);

endmodule

`default_nettype wire

// ==== source/cart_ram_result.sv ====
// Cart RAM and read result
`timescale 1ns/1ps
`default_nettype none

module cart_ram_result #(
	parameter int RAM_BANKS_LOG2 = 4
) (
	input  wire                          clk_sys,
	input  wire                          reset,
	input  wire                          do_write,
	input  wire                          do_read,
	input  wire                          respond,
	input  wire                          req,
	input  wire                          is_rom_area,
	input  wire                          is_ram_area,
	input  wire mbc_pkg::cpu_addr_t      cur_addr,
	input  wire mbc_pkg::cpu_data_t      cur_wdata,
	input  wire [RAM_BANKS_LOG2+12:0]    ram_addr,
	input  wire mbc_pkg::mbc_kind_t      kind,
	input  wire                          ram_enable,
	input  wire                          rtc_mode,
	input  wire mbc_pkg::cpu_data_t      rom_data,   // external rom, combinational
	output mbc_pkg::cpu_data_t           rdata,
	output logic                         ack
);

	localparam int RAM_DEPTH = 1 << (RAM_BANKS_LOG2 + 13);  // 8k per bank

	mbc_pkg::cpu_data_t cram [0:RAM_DEPTH-1];
	mbc_pkg::cpu_data_t ram_q;      // registered ram byte
	mbc_pkg::cpu_data_t read_val;
	logic               rd_pending; // current transaction is a read
	logic               mbc2_nib;   // a000-a1ff on mbc2, 512 x 4 bit

	// ----------------------------------------------------------
	// banked ram, one port
	// ----------------------------------------------------------

	always_ff @(posedge clk_sys) begin
		if (do_write && is_ram_area)
			cram[ram_addr] <= cur_wdata;   // enable does not gate the write
		if (do_read)
			ram_q <= cram[ram_addr];
	end

	// ----------------------------------------------------------
	// read value
	// ----------------------------------------------------------

	assign mbc2_nib = (kind == mbc_pkg::kind_mbc2) && (cur_addr[15:9] == 7'b1010000);

	always_comb begin
		if (is_rom_area)
			read_val = rom_data;
		else if (!is_ram_area)
			read_val = 8'hff;              // vram, wram and io are not ours
		else if (!ram_enable)
			read_val = 8'hff;
		else if (mbc2_nib)
			read_val = {4'hf, ram_q[3:0]}; // upper nibble floats high
		else if (rtc_mode && kind == mbc_pkg::kind_mbc3)
			read_val = 8'h00;              // no clock behind the rtc registers
		else
			read_val = ram_q;
	end

	// rdata holds until the next respond
	always_ff @(posedge clk_sys) begin
		if (respond)
			rdata <= rd_pending ? read_val : 8'hff;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rd_pending <= 1'b0;
			ack        <= 1'b0;
		end else begin
			if (do_read)
				rd_pending <= 1'b1;
			else if (do_write)
				rd_pending <= 1'b0;

			if (respond)
				ack <= 1'b1;
			else if (!req)
				ack <= 1'b0;   // drops on the first edge that sees req low
		end
	end

endmodule

`default_nettype wire

// ==== source/mbc_pkg.sv ====
// Cartridge mapper shared definitions
`default_nettype none

package mbc_pkg;

	// ----------------------------------------------------------
	// widths with a meaning
	// ----------------------------------------------------------

	typedef logic [15:0] cpu_addr_t;   // cpu address space
	typedef logic [7:0]  cpu_data_t;   // one bus byte
	typedef logic [15:0] dl_word_t;    // even byte in [15:8]
	typedef logic [8:0]  rom_bank_t;   // up to 512 banks of 16k
	typedef logic [3:0]  ram_bank_t;   // up to 16 banks of 8k
	typedef logic [22:0] rom_addr_t;   // 8 MB byte address
	typedef logic [7:0]  size_code_t;  // raw header byte

	// controller kinds, decoded from the cart type byte
	typedef enum logic [2:0] {
		kind_none,
		kind_mbc1,
		kind_mbc2,
		kind_mbc3,
		kind_mbc5
	} mbc_kind_t;

	// four-phase req/ack sequencer
	typedef enum logic [2:0] {
		st_idle,     // waiting for req
		st_issue,    // request latched
		st_execute,  // register and ram writes land here
		st_respond,  // result and ack registered on exit
		st_release   // ack high, waiting for req low
	} bus_state_t;

	// ----------------------------------------------------------
	// header words on the download port
	// ----------------------------------------------------------

	parameter cpu_addr_t HDR_TYPE_ADDR = 16'h0146;  // type in the high byte
	parameter cpu_addr_t HDR_SIZE_ADDR = 16'h0148;  // {ram size, rom size}

endpackage

`default_nettype wire

// ==== tests/tb_model.svh ====
// Mapper reference model

// ----------------------------------------------------------
// model copy of header fields and controller registers
// ----------------------------------------------------------

mbc_pkg::mbc_kind_t m_kind     = mbc_pkg::kind_none;
logic [8:0]         m_rom_mask = 9'd1;     // empty header is a 32k rom
logic [3:0]         m_ram_mask = 4'd0;
logic [8:0]         m_rom_bank = 9'd1;
logic [3:0]         m_ram_bank = 4'd0;
logic               m_mode     = 1'b0;
logic               m_rtc      = 1'b0;
logic               m_ram_en   = 1'b0;
logic               m_known;               // expected byte is defined
logic [7:0]         m_ram [0:131071];      // 16 banks of 8k
bit                 m_valid [0:131071];    // byte written at least once

// rom contents, low address byte mixed with the bank number
function automatic logic [7:0] rom_byte(input logic [22:0] ra);
	return ra[7:0] ^ ra[21:14];
endfunction

function automatic logic [31:0] xorshift_next(input logic [31:0] s);
	s = s ^ (s << 13);
	s = s ^ (s >> 17);
	s = s ^ (s << 5);
	return s;
endfunction

// header download, the reset pulse after it clears the registers
function automatic void model_header(input logic [7:0] type_code,
		input logic [7:0] rom_code, input logic [7:0] ram_code);
	int code;
	int span;
	case (type_code)
		8'h01, 8'h02, 8'h03:                      m_kind = mbc_pkg::kind_mbc1;
		8'h05, 8'h06:                             m_kind = mbc_pkg::kind_mbc2;
		8'h0f, 8'h10, 8'h11, 8'h12, 8'h13:        m_kind = mbc_pkg::kind_mbc3;
		8'h19, 8'h1a, 8'h1b, 8'h1c, 8'h1d, 8'h1e: m_kind = mbc_pkg::kind_mbc5;
		default:                                  m_kind = mbc_pkg::kind_none;
	endcase
	code = rom_code;
	span = (code <= 8) ? (1 << (code + 1)) - 1 : 127;   // banks minus one
	m_rom_mask = span[8:0];
	m_ram_mask = (ram_code <= 8'd2) ? 4'd0 : (ram_code == 8'd3) ? 4'd3 : 4'd15;
	m_rom_bank = 9'd1;
	m_ram_bank = 4'd0;
	m_mode     = 1'b0;
	m_rtc      = 1'b0;
	m_ram_en   = 1'b0;
endfunction

function automatic void model_reg_write(input logic [15:0] a, input logic [7:0] wd);
	case (a[15:13])
		3'd0: m_ram_en = (wd[3:0] == 4'ha);
		3'd1: begin
			if (m_kind == mbc_pkg::kind_mbc5 && a[12])
				m_rom_bank[8] = wd[0];             // 3000-3fff
			else if (m_kind == mbc_pkg::kind_mbc5)
				m_rom_bank[7:0] = wd;
			else
				m_rom_bank = (wd[6:0] == 7'd0) ? 9'd1 : {2'b00, wd[6:0]};
		end
		3'd2: begin
			if (m_kind == mbc_pkg::kind_mbc3) begin
				m_rtc = wd[3];
				if (!wd[3])
					m_ram_bank = {2'b00, wd[1:0]};
			end else if (m_kind == mbc_pkg::kind_mbc5)
				m_ram_bank = wd[3:0];
			else
				m_ram_bank = {2'b00, wd[1:0]};
		end
		3'd3: begin
			if (m_kind == mbc_pkg::kind_mbc1)
				m_mode = wd[0];
		end
		default: ;
	endcase
endfunction

// mbc1 upper bank bits, only in the switched window or in mode 1
function automatic logic [1:0] model_bank2(input logic [15:0] a);
	return (a[14] || m_mode) ? m_ram_bank[1:0] : 2'b00;
endfunction

function automatic logic [22:0] model_rom_addr(input logic [15:0] a);
	logic [8:0] eff;
	logic [8:0] bank;
	eff = (a < 16'h4000) ? 9'd0 : m_rom_bank;
	case (m_kind)
		mbc_pkg::kind_mbc1: bank = {2'b00, model_bank2(a), eff[4:0]};
		mbc_pkg::kind_mbc2: bank = {2'b00, eff[6:0]};
		mbc_pkg::kind_mbc3: bank = {2'b00, eff[6:0]};
		mbc_pkg::kind_mbc5: bank = eff;
		default:            bank = {8'd0, a[14]};   // plain 32k
	endcase
	return {bank & m_rom_mask, a[13:0]};
endfunction

function automatic logic [16:0] model_ram_index(input logic [15:0] a);
	logic [3:0] bank;
	if (m_kind == mbc_pkg::kind_mbc1)
		bank = {2'b00, model_bank2(a)};
	else if (m_kind == mbc_pkg::kind_mbc3 || m_kind == mbc_pkg::kind_mbc5)
		bank = m_ram_bank;
	else
		bank = 4'd0;
	return {bank & m_ram_mask, a[12:0]};
endfunction

// applies one bus access to the model, returns the expected rdata
function automatic logic [7:0] model_read(input logic we, input logic [15:0] a,
		input logic [7:0] wd);
	logic [16:0] ri;
	ri = model_ram_index(a);
	m_known = 1'b1;
	if (we) begin
		if (a < 16'h8000)
			model_reg_write(a, wd);
		else if (a[15:13] == 3'b101) begin
			m_ram[ri]   = wd;                      // enable does not gate it
			m_valid[ri] = 1'b1;
		end
		return 8'hff;
	end
	if (a < 16'h8000)
		return rom_byte(model_rom_addr(a));
	if (a[15:13] != 3'b101 || !m_ram_en)
		return 8'hff;                              // not ours, or ram closed
	if (m_rtc && m_kind == mbc_pkg::kind_mbc3)
		return 8'h00;
	m_known = m_valid[ri];
	if (m_kind == mbc_pkg::kind_mbc2 && a < 16'ha200)
		return {4'hf, m_ram[ri][3:0]};             // nibble ram
	return m_ram[ri];
endfunction

// ==== tests/tb_cart_mapper.sv ====
// Cartridge mapper testbench
`timescale 1ns/1ps
`default_nettype none

module tb_cart_mapper;

	localparam int TIMEOUT_CYCLES = 20000;   // ~600 accesses of up to 13 cycles, plus margin

	logic                clk_sys = 1'b0;
	logic                reset;
	logic                dl_wr;
	mbc_pkg::cpu_addr_t  dl_addr;
	mbc_pkg::dl_word_t   dl_data;
	logic                req;
	logic                we;
	mbc_pkg::cpu_addr_t  addr;
	mbc_pkg::cpu_data_t  wdata;
	wire                 ack;
	mbc_pkg::cpu_data_t  rdata;
	mbc_pkg::rom_addr_t  rom_addr;
	mbc_pkg::cpu_data_t  rom_data;

	`include "tb_model.svh"

	logic [31:0]         rng = 32'd91;    // xorshift state
	logic [7:0]          exp_rdata;
	logic [22:0]         exp_rom_addr;
	logic                exp_known;
	logic [15:0]         exp_addr;
	int                  err_data = 0;
	int                  err_hs = 0;
	int                  n_checked = 0;
	int                  cycles = 0;
	int                  req_edge = 0;    // edge that first saw req high
	int                  drop_edge = 0;   // edge that first saw req low
	logic                req_q;
	logic                ack_q;

	assign rom_data = rom_byte(rom_addr);   // external rom, combinational

	cart_mapper_top cart_mapper_top_inst (
		.clk_sys(clk_sys), .reset(reset),
		.dl_wr(dl_wr), .dl_addr(dl_addr), .dl_data(dl_data),
		.req(req), .we(we), .addr(addr), .wdata(wdata), .ack(ack), .rdata(rdata),
		.rom_addr(rom_addr), .rom_data(rom_data)
	);

	always #4 clk_sys = ~clk_sys;   // 125 MHz

	// ----------------------------------------------------------
	// host side tasks
	// ----------------------------------------------------------

	// header words, then a reset pulse
	task automatic load_header(input logic [7:0] type_code, input logic [7:0] rom_code,
			input logic [7:0] ram_code);
		@(posedge clk_sys);
		dl_wr   <= 1'b1;
		dl_addr <= mbc_pkg::HDR_TYPE_ADDR;
		dl_data <= {type_code, 8'h00};
		@(posedge clk_sys);
		dl_addr <= mbc_pkg::HDR_SIZE_ADDR;
		dl_data <= {ram_code, rom_code};
		@(posedge clk_sys);
		dl_wr <= 1'b0;
		reset <= 1'b1;
		repeat (2) @(posedge clk_sys);
		reset <= 1'b0;
		model_header(type_code, rom_code, ram_code);
	endtask

	// one four-phase access, req held for hold extra cycles after ack
	task automatic bus_cycle(input logic w, input logic [15:0] a, input logic [7:0] d,
			input int hold);
		int waited;
		exp_rdata    = model_read(w, a, d);
		exp_known    = m_known;
		exp_rom_addr = model_rom_addr(a);
		exp_addr     = a;
		@(posedge clk_sys);
		req   <= 1'b1;
		we    <= w;
		addr  <= a;
		wdata <= d;
		waited = 0;
		do begin
			@(posedge clk_sys);
			waited++;
		end while (ack !== 1'b1 && waited < 40);
		if (ack !== 1'b1) begin
			$display("no ack within 40 cycles for the access at %h", a);
			err_hs++;
		end
		repeat (hold) @(posedge clk_sys);
		req <= 1'b0;
		waited = 0;
		do begin
			@(posedge clk_sys);
			waited++;
		end while (ack !== 1'b0 && waited < 40);
		if (ack !== 1'b0) begin
			$display("ack stayed high after req was dropped at %h", a);
			err_hs++;
		end
	endtask

	// ----------------------------------------------------------
	// compare at each ack edge
	// ----------------------------------------------------------

	always @(posedge clk_sys) begin
		if (reset) begin
			req_q = 1'b0;
			ack_q = 1'b0;
		end else begin
			if (req && !req_q)
				req_edge = cycles;
			if (!req && req_q)
				drop_edge = cycles;
			if (ack && !ack_q) begin
				n_checked++;
				if (cycles - req_edge != 4) begin   // set at edge 3, seen one edge later
					$display("ack rose %0d edges after req was seen instead of 3",
						cycles - req_edge - 1);
					err_hs++;
				end
				if (rom_addr !== exp_rom_addr) begin
					$display("** Error: rom_addr = %h, expected %h (addr %h)",
						rom_addr, exp_rom_addr, exp_addr);
					err_data++;
				end
				if (exp_known && rdata !== exp_rdata) begin
					$display("** Error: rdata = %h, expected %h (addr %h)",
						rdata, exp_rdata, exp_addr);
					err_data++;
				end
			end
			if (!ack && ack_q && cycles - drop_edge != 1) begin
				$display("ack fell %0d edges after req dropped instead of 1", cycles - drop_edge);
				err_hs++;
			end
			req_q = req;
			ack_q = ack;
		end
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("run stopped at the cycle limit %0d before the tests finished", cycles);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	// ----------------------------------------------------------
	// stimulus
	// ----------------------------------------------------------

	initial begin
		int          i;
		int          b;
		logic [7:0]  t;
		logic [2:0]  sel;
		logic [15:0] a;
		logic        w;
		logic [7:0]  d;
		reset   = 1'b1;
		dl_wr   = 1'b0;
		dl_addr = '0;
		dl_data = '0;
		req     = 1'b0;
		we      = 1'b0;
		addr    = '0;
		wdata   = '0;
		repeat (16) @(posedge clk_sys);
		reset <= 1'b0;
		@(posedge clk_sys);
		if (ack !== 1'b0) begin
			$display("** Error: ack = %h after reset, expected 0", ack);
			err_data++;
		end
		bus_cycle(1'b0, 16'h4000, 8'h00, 0);   // no header, straight 32k map

		// mbc5, 8 banks: bank 10d folds to 5
		load_header(8'h19, 8'h02, 8'h03);
		bus_cycle(1'b1, 16'h2000, 8'h0d, 0);
		bus_cycle(1'b1, 16'h3000, 8'h01, 1);
		bus_cycle(1'b0, 16'h4000, 8'h00, 0);
		bus_cycle(1'b0, 16'h0000, 8'h00, 2);
		bus_cycle(1'b0, 16'h3fff, 8'h00, 0);

		// mbc1 bank 0 alias, then mode 1 with bank2 = 2
		load_header(8'h01, 8'h06, 8'h03);
		bus_cycle(1'b1, 16'h2000, 8'h00, 0);
		bus_cycle(1'b0, 16'h4000, 8'h00, 0);
		bus_cycle(1'b1, 16'h6000, 8'h01, 0);
		bus_cycle(1'b1, 16'h4000, 8'h02, 0);
		bus_cycle(1'b0, 16'h0000, 8'h00, 3);
		bus_cycle(1'b0, 16'h4123, 8'h00, 0);

		// cart ram: closed, then per bank under the mask
		bus_cycle(1'b0, 16'ha010, 8'h00, 0);
		bus_cycle(1'b1, 16'h0000, 8'h0a, 0);
		for (b = 0; b < 4; b++) begin
			bus_cycle(1'b1, 16'h4000, b[7:0], 0);
			bus_cycle(1'b1, 16'ha010, 8'h50 + b[7:0], 0);
		end
		for (b = 0; b < 4; b++) begin
			bus_cycle(1'b1, 16'h4000, b[7:0], 0);
			bus_cycle(1'b0, 16'ha010, 8'h00, b % 3);
		end
		load_header(8'h06, 8'h03, 8'h00);   // mbc2 nibbles
		bus_cycle(1'b1, 16'h0000, 8'h0a, 0);
		bus_cycle(1'b1, 16'ha005, 8'h3c, 0);
		bus_cycle(1'b0, 16'ha005, 8'h00, 0);
		load_header(8'h10, 8'h04, 8'h03);   // mbc3 ram then rtc select
		bus_cycle(1'b1, 16'h0000, 8'h0a, 0);
		bus_cycle(1'b1, 16'h4000, 8'h01, 0);
		bus_cycle(1'b1, 16'ha020, 8'h77, 0);
		bus_cycle(1'b0, 16'ha020, 8'h00, 0);
		bus_cycle(1'b1, 16'h4000, 8'h08, 0);
		bus_cycle(1'b0, 16'ha020, 8'h00, 5);

		// random accesses, a new kind every 80
		for (i = 0; i < 400; i++) begin
			if (i % 80 == 0) begin
				case (i / 80)
					0:       t = 8'h00;
					1:       t = 8'h03;
					2:       t = 8'h06;
					3:       t = 8'h13;
					default: t = 8'h1b;
				endcase
				rng = xorshift_next(rng);
				load_header(t, rng[3:0] % 10, rng[6:4] % 5);   // code 9 is out of range
			end
			rng = xorshift_next(rng);
			sel = rng[2:0];
			w   = 1'b0;
			d   = rng[23:16];
			if (sel <= 3'd1) begin
				w = 1'b1;
				a = {1'b0, rng[6:5], rng[7], 12'h000};   // register by 15:13, 12 for mbc5
				if (rng[31])
					d = 8'h0a;
			end else if (sel <= 3'd3) begin
				a = {1'b0, rng[30:16]};
			end else if (sel <= 3'd6) begin
				w = rng[9];
				a = {3'b101, rng[12], 9'd0, rng[5:3]};   // few bytes so reads hit writes
			end else begin
				w = rng[10];
				a = {rng[11] ? 3'b110 : 3'b100, rng[28:16]};
			end
			bus_cycle(w, a, d, rng[27:25] % 6);
		end

		repeat (4) @(posedge clk_sys);
		$display("errors: %0d data, %0d handshake, %0d accesses checked",
			err_data, err_hs, n_checked);
		if (err_data == 0 && err_hs == 0 && n_checked > 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
